// ==== test/cdc_cases.txt ====
# name direction(0 axi->noc, 1 noc->axi) bypass type(hex) payload(hex) stall
# Lines sharing a name form one test, the largest stall applies to the group
order_a2n 0 0 0 10000001 0
order_a2n 0 0 1 10000002 0
order_a2n 0 0 1 10000003 0
order_a2n 0 0 2 10000004 0
order_a2n 0 0 3 deadbeef 0
order_a2n 0 0 0 20000001 0
order_a2n 0 0 1 ffffffff 0
order_a2n 0 0 2 00000000 0
order_n2a 1 0 0 30000001 0
order_n2a 1 0 1 30000002 0
order_n2a 1 0 2 30000003 0
order_n2a 1 0 3 cafef00d 0
order_n2a 1 0 0 a5a5a5a5 0
order_n2a 1 0 1 5a5a5a5a 0
order_n2a 1 0 1 0f0f0f0f 0
order_n2a 1 0 2 f0f0f0f0 0
backpressure_a2n 0 0 0 40000001 60
backpressure_a2n 0 0 1 40000002 60
backpressure_a2n 0 0 1 40000003 60
backpressure_a2n 0 0 1 40000004 60
backpressure_a2n 0 0 1 40000005 60
backpressure_a2n 0 0 1 40000006 60
backpressure_a2n 0 0 2 40000007 60
backpressure_n2a 1 0 0 50000001 40
backpressure_n2a 1 0 1 50000002 40
backpressure_n2a 1 0 1 50000003 40
backpressure_n2a 1 0 1 50000004 40
backpressure_n2a 1 0 1 50000005 40
backpressure_n2a 1 0 2 50000006 40
both_ways 0 0 0 60000001 3
both_ways 1 0 0 70000001 3
both_ways 0 0 1 60000002 3
both_ways 1 0 1 70000002 3
both_ways 0 0 1 60000003 3
both_ways 1 0 1 70000003 3
both_ways 0 0 2 60000004 3
both_ways 1 0 2 70000004 3
both_ways 0 0 3 60000005 3
both_ways 1 0 3 70000005 3
both_ways 0 0 0 12345678 3
both_ways 0 0 2 87654321 3
both_ways 1 0 0 13579bdf 3
both_ways 1 0 2 2468ace0 3
bypass 0 1 0 80000001 0
bypass 1 1 0 90000001 0
bypass 0 1 1 80000002 0
bypass 1 1 1 90000002 0
bypass 0 1 2 80000003 0
bypass 1 1 2 90000003 0
bypass 0 1 3 80000004 0
bypass 1 1 3 90000004 0
after_bypass 0 0 3 b0000001 0
after_bypass 1 0 3 c0000001 0

// ==== all.f ====
src/ravenoc_pkg.sv
src/ptr_sync.sv
src/async_gp_fifo.sv
src/cdc_pkt.sv
test/cdc_pkt_props.sv
test/tb_cdc_pkt.sv

// ==== Makefile ====
# Verilator flow for the packet CDC testbench

VERILATOR ?= verilator
TOP       ?= tb_cdc_pkt
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_cdc_pkt.sv ====
`default_nettype none

module tb_cdc_pkt;
  timeunit 1ns;
  timeprecision 100ps;
  import ravenoc_pkg::*;

  // Cycles a loop may wait for progress before giving up
  localparam int IDLE_LIMIT = 200;
  // Stall length from which the sink counts as fully blocked
  localparam int LONG_STALL = 20;

  logic        clk_axi;
  logic        clk_noc;
  logic        rst_n_i;
  logic        bypass_cdc_i;
  logic        axi_valid_i;
  logic        axi_ready_o;
  logic        noc_valid_o;
  logic        noc_ready_i;
  logic        rx_noc_valid_i;
  logic        rx_noc_ready_o;
  logic        rx_axi_valid_o;
  logic        rx_axi_ready_i;
  s_flit_req_t axi_flit_i;
  s_flit_req_t noc_flit_o;
  s_flit_req_t rx_noc_flit_i;
  s_flit_req_t rx_axi_flit_o;

  // Cases of the group being collected
  string                 grp_name;
  int                    grp_stall;
  logic                  grp_bypass;
  int                    grp_dir[$];
  logic [FLIT_WIDTH-1:0] grp_flit[$];

  // Source queues and scoreboards, one pair per direction
  logic [FLIT_WIDTH-1:0] a2n_src[$];
  logic [FLIT_WIDTH-1:0] a2n_exp[$];
  logic [FLIT_WIDTH-1:0] n2a_src[$];
  logic [FLIT_WIDTH-1:0] n2a_exp[$];
  logic                  a2n_stalled;
  logic                  n2a_stalled;

  int seed = 84457;
  int seed_noc;
  int seed_axi;

  cdc_pkt dut_i (.*);

  initial begin
    clk_axi = 1'b0;
    forever #20 clk_axi = ~clk_axi;
  end

  // Odd ratio to the AXI clock so edges really drift
  initial begin
    clk_noc = 1'b0;
    forever #14 clk_noc = ~clk_noc;
  end

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s expected %0h actual %0h", name, exp_v, act_v);
      $display("Errors found");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout in %s: %s", grp_name, what);
    $display("Errors found");
    $fatal(1, "wait loop gave up");
  endtask

  //--------------------------------------------------------------------
  // AXI to NoC traffic
  //--------------------------------------------------------------------
  task automatic feed_axi_side(input int held_exp);
    int   idle;
    int   held;
    logic rdy;
    idle = 0;
    held = 0;
    if (a2n_src.size() == 0) return;
    @(posedge clk_axi);
    #2;
    while (a2n_src.size() > 0) begin
      axi_valid_i = 1'b1;
      axi_flit_i  = s_flit_req_t'({1'b1, a2n_src[0]});
      // Values are settled half a cycle before the accepting edge
      @(negedge clk_axi);
      rdy = axi_ready_o;
      @(posedge clk_axi);
      #2;
      if (rdy) begin
        void'(a2n_src.pop_front());
        idle = 0;
        if (a2n_stalled) held++;
      end else if (++idle > IDLE_LIMIT) begin
        report_timeout("axi_ready_o never rose for a waiting AXI flit");
      end
    end
    axi_valid_i = 1'b0;
    axi_flit_i  = '0;
    if (held_exp >= 0) check_value({grp_name, "_a2n_held"}, 64'(held_exp), 64'(held));
  endtask

  task automatic drain_noc_side();
    int          idle;
    int          cyc;
    logic        rdy;
    logic        v;
    s_flit_req_t f;
    logic [31:0] rnd;
    idle = 0;
    cyc  = 0;
    if (a2n_exp.size() == 0) return;
    @(posedge clk_noc);
    #2;
    while (a2n_exp.size() > 0) begin
      rnd         = $random(seed_noc);
      a2n_stalled = (cyc < grp_stall);
      rdy         = !a2n_stalled && (rnd[1:0] != 2'b00);
      noc_ready_i = rdy;
      @(negedge clk_noc);
      v = noc_valid_o;
      f = noc_flit_o;
      @(posedge clk_noc);
      #2;
      cyc++;
      if (v && rdy) begin
        check_value(grp_name, 64'({1'b1, a2n_exp[0]}), 64'(f));
        void'(a2n_exp.pop_front());
        idle = 0;
      end else if (++idle > IDLE_LIMIT) begin
        report_timeout("expected flit never showed on noc_valid_o");
      end
    end
    noc_ready_i = 1'b0;
    a2n_stalled = 1'b0;
  endtask

  //--------------------------------------------------------------------
  // NoC to AXI traffic
  //--------------------------------------------------------------------
  task automatic feed_noc_side(input int held_exp);
    int   idle;
    int   held;
    logic rdy;
    idle = 0;
    held = 0;
    if (n2a_src.size() == 0) return;
    @(posedge clk_noc);
    #2;
    while (n2a_src.size() > 0) begin
      rx_noc_valid_i = 1'b1;
      rx_noc_flit_i  = s_flit_req_t'({1'b1, n2a_src[0]});
      @(negedge clk_noc);
      rdy = rx_noc_ready_o;
      @(posedge clk_noc);
      #2;
      if (rdy) begin
        void'(n2a_src.pop_front());
        idle = 0;
        if (n2a_stalled) held++;
      end else if (++idle > IDLE_LIMIT) begin
        report_timeout("rx_noc_ready_o never rose for a waiting NoC flit");
      end
    end
    rx_noc_valid_i = 1'b0;
    rx_noc_flit_i  = '0;
    if (held_exp >= 0) check_value({grp_name, "_n2a_held"}, 64'(held_exp), 64'(held));
  endtask

  task automatic drain_axi_side();
    int          idle;
    int          cyc;
    logic        rdy;
    logic        v;
    s_flit_req_t f;
    logic [31:0] rnd;
    idle = 0;
    cyc  = 0;
    if (n2a_exp.size() == 0) return;
    @(posedge clk_axi);
    #2;
    while (n2a_exp.size() > 0) begin
      rnd            = $random(seed_axi);
      n2a_stalled    = (cyc < grp_stall);
      rdy            = !n2a_stalled && (rnd[1:0] != 2'b00);
      rx_axi_ready_i = rdy;
      @(negedge clk_axi);
      v = rx_axi_valid_o;
      f = rx_axi_flit_o;
      @(posedge clk_axi);
      #2;
      cyc++;
      if (v && rdy) begin
        check_value(grp_name, 64'({1'b1, n2a_exp[0]}), 64'(f));
        void'(n2a_exp.pop_front());
        idle = 0;
      end else if (++idle > IDLE_LIMIT) begin
        report_timeout("expected flit never showed on rx_axi_valid_o");
      end
    end
    rx_axi_ready_i = 1'b0;
    n2a_stalled    = 1'b0;
  endtask

  //--------------------------------------------------------------------
  // Direct path with both FIFOs idle
  //--------------------------------------------------------------------
  task automatic run_bypass();
    logic [31:0] rnd;
    @(posedge clk_axi);
    #2;
    bypass_cdc_i = 1'b1;
    foreach (grp_dir[i]) begin
      rnd = $random(seed_axi);
      if (grp_dir[i] == 0) begin
        axi_valid_i = rnd[1];
        axi_flit_i  = s_flit_req_t'({1'b1, grp_flit[i]});
        noc_ready_i = rnd[0];
        #1;
        check_value({grp_name, "_valid"}, 64'(rnd[1]), 64'(noc_valid_o));
        check_value({grp_name, "_flit"}, 64'(axi_flit_i), 64'(noc_flit_o));
        check_value({grp_name, "_ready"}, 64'(rnd[0]), 64'(axi_ready_o));
        axi_valid_i = 1'b0;
        axi_flit_i  = '0;
        noc_ready_i = 1'b0;
      end else begin
        rx_noc_valid_i = rnd[1];
        rx_noc_flit_i  = s_flit_req_t'({1'b1, grp_flit[i]});
        rx_axi_ready_i = rnd[0];
        #1;
        check_value({grp_name, "_valid"}, 64'(rnd[1]), 64'(rx_axi_valid_o));
        check_value({grp_name, "_flit"}, 64'(rx_noc_flit_i), 64'(rx_axi_flit_o));
        check_value({grp_name, "_ready"}, 64'(rnd[0]), 64'(rx_noc_ready_o));
        rx_noc_valid_i = 1'b0;
        rx_noc_flit_i  = '0;
        rx_axi_ready_i = 1'b0;
      end
      @(posedge clk_axi);
      #2;
    end
    // Let both sides see idle inputs before the FIFOs come back
    repeat (2) @(posedge clk_axi);
    #2;
    bypass_cdc_i = 1'b0;
    repeat (2) @(posedge clk_axi);
    #2;
  endtask

  // Long stall blocks the sink, so exactly one FIFO worth gets in
  function automatic int held_limit(input int count);
    if (grp_stall < LONG_STALL) return -1;
    return (count < FIFO_SLOTS) ? count : FIFO_SLOTS;
  endfunction

  task automatic run_group();
    int ha;
    int hn;
    if (grp_dir.size() == 0) return;
    if (grp_bypass) begin
      run_bypass();
    end else begin
      foreach (grp_dir[i]) begin
        if (grp_dir[i] == 0) begin
          a2n_src.push_back(grp_flit[i]);
          a2n_exp.push_back(grp_flit[i]);
        end else begin
          n2a_src.push_back(grp_flit[i]);
          n2a_exp.push_back(grp_flit[i]);
        end
      end
      ha          = held_limit(a2n_src.size());
      hn          = held_limit(n2a_src.size());
      a2n_stalled = (grp_stall > 0);
      n2a_stalled = (grp_stall > 0);
      fork
        feed_axi_side(ha);
        drain_noc_side();
        feed_noc_side(hn);
        drain_axi_side();
      join
      // A trailing extra flit would show within the crossing latency
      repeat (CDC_TAPS + 2) @(posedge clk_axi);
      @(negedge clk_noc);
      check_value({grp_name, "_a2n_left"}, 64'(0), 64'(noc_valid_o));
      @(negedge clk_axi);
      check_value({grp_name, "_n2a_left"}, 64'(0), 64'(rx_axi_valid_o));
    end
    grp_dir.delete();
    grp_flit.delete();
  endtask

  initial begin
    string       line;
    string       name;
    int          fd;
    int          n;
    int          dir;
    int          byp;
    int          typ;
    int          stall;
    int          case_cnt;
    logic [31:0] data;
    seed_noc       = seed;
    seed_axi       = seed + 1;
    case_cnt       = 0;
    rst_n_i        = 1'b0;
    bypass_cdc_i   = 1'b0;
    axi_valid_i    = 1'b0;
    axi_flit_i     = '0;
    noc_ready_i    = 1'b0;
    rx_noc_valid_i = 1'b0;
    rx_noc_flit_i  = '0;
    rx_axi_ready_i = 1'b0;
    a2n_stalled    = 1'b0;
    n2a_stalled    = 1'b0;
    grp_name       = "";
    grp_stall      = 0;
    grp_bypass     = 1'b0;
    repeat (4) @(posedge clk_axi);
    #2;
    rst_n_i = 1'b1;
    @(negedge clk_axi);
    check_value("reset_noc_valid", 64'(0), 64'(noc_valid_o));
    check_value("reset_rx_axi_valid", 64'(0), 64'(rx_axi_valid_o));
    check_value("reset_axi_ready", 64'(1), 64'(axi_ready_o));
    check_value("reset_rx_noc_ready", 64'(1), 64'(rx_noc_ready_o));
    fd = $fopen("test/cdc_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/cdc_cases.txt");
      $display("Errors found");
      $fatal(1, "case file missing");
    end
    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %d %d %h %h %d", name, dir, byp, typ, data, stall);
        if (n == 6) begin
          // New test name closes the previous group
          if (name != grp_name) begin
            run_group();
            grp_name  = name;
            grp_stall = 0;
          end
          grp_bypass = byp[0];
          grp_dir.push_back(dir);
          grp_flit.push_back({typ[1:0], data});
          if (stall > grp_stall) grp_stall = stall;
          case_cnt++;
        end
      end
    end
    run_group();
    $fclose(fd);
    if (case_cnt == 0) begin
      $display("No cases found in test/cdc_cases.txt");
      $display("Errors found");
      $fatal(1, "empty case file");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/cdc_pkt_props.sv ====
`default_nettype none

module cdc_pkt_props #(
  parameter int TAPS = ravenoc_pkg::CDC_TAPS
) (
  input logic                     clk_axi,
  input logic                     clk_noc,
  input logic                     rst_n_i,
  input logic                     bypass_cdc_i,
  input logic                     axi_ready_o,
  input logic                     noc_valid_o,
  input ravenoc_pkg::s_flit_req_t noc_flit_o,
  input logic                     noc_ready_i,
  input logic                     rx_noc_ready_o,
  input logic                     rx_axi_valid_o,
  input ravenoc_pkg::s_flit_req_t rx_axi_flit_o,
  input logic                     rx_axi_ready_i,
  input logic                     a2n_empty,
  input logic                     n2a_empty
);
  timeunit 1ns;
  timeprecision 100ps;

  // Freed slot needs the pointer crossing plus a little slack
  localparam int BLOCK_LIMIT = 2 * TAPS + 2;

  // Run length of ready low while the FIFO holds nothing
  logic [3:0] a2n_block_q;
  logic [3:0] n2a_block_q;

  always_ff @(posedge clk_axi) begin
    if (!rst_n_i || bypass_cdc_i) begin
      a2n_block_q <= '0;
    end else if (!axi_ready_o && a2n_empty) begin
      a2n_block_q <= a2n_block_q + 4'd1;
    end else begin
      a2n_block_q <= '0;
    end
  end

  always_ff @(posedge clk_noc) begin
    if (!rst_n_i || bypass_cdc_i) begin
      n2a_block_q <= '0;
    end else if (!rx_noc_ready_o && n2a_empty) begin
      n2a_block_q <= n2a_block_q + 4'd1;
    end else begin
      n2a_block_q <= '0;
    end
  end

  reset_state: assert property (@(posedge clk_axi) $rose(rst_n_i) |->
      !noc_valid_o && !rx_axi_valid_o && axi_ready_o && rx_noc_ready_o)
    else $error("outputs not idle right after reset");

  noc_hold: assert property (@(posedge clk_noc) disable iff (!rst_n_i || bypass_cdc_i)
      noc_valid_o && !noc_ready_i |=> noc_valid_o && $stable(noc_flit_o))
    else $error("noc flit changed while stalled");

  axi_hold: assert property (@(posedge clk_axi) disable iff (!rst_n_i || bypass_cdc_i)
      rx_axi_valid_o && !rx_axi_ready_i |=> rx_axi_valid_o && $stable(rx_axi_flit_o))
    else $error("rx axi flit changed while stalled");

  a2n_ready_back: assert property (@(posedge clk_axi) disable iff (!rst_n_i)
      int'(a2n_block_q) <= BLOCK_LIMIT)
    else $error("axi_ready_o stuck low on an empty FIFO");

  n2a_ready_back: assert property (@(posedge clk_noc) disable iff (!rst_n_i)
      int'(n2a_block_q) <= BLOCK_LIMIT)
    else $error("rx_noc_ready_o stuck low on an empty FIFO");

endmodule

bind cdc_pkt cdc_pkt_props #(.TAPS(CDC_TAPS)) u_props (
  .clk_axi        (clk_axi),
  .clk_noc        (clk_noc),
  .rst_n_i        (rst_n_i),
  .bypass_cdc_i   (bypass_cdc_i),
  .axi_ready_o    (axi_ready_o),
  .noc_valid_o    (noc_valid_o),
  .noc_flit_o     (noc_flit_o),
  .noc_ready_i    (noc_ready_i),
  .rx_noc_ready_o (rx_noc_ready_o),
  .rx_axi_valid_o (rx_axi_valid_o),
  .rx_axi_flit_o  (rx_axi_flit_o),
  .rx_axi_ready_i (rx_axi_ready_i),
  .a2n_empty      (a2n_empty),
  .n2a_empty      (n2a_empty)
);

`default_nettype wire

// ==== src/cdc_pkt.sv ====
`default_nettype none

module cdc_pkt #(
  parameter int CDC_TAPS = ravenoc_pkg::CDC_TAPS
) (
  input  logic                     clk_axi,
  input  logic                     clk_noc,
  input  logic                     rst_n_i,
  input  logic                     bypass_cdc_i,
  // Packet generator feeding the NoC
  input  logic                     axi_valid_i,
  input  ravenoc_pkg::s_flit_req_t axi_flit_i,
  output logic                     axi_ready_o,
  // Router port receiving from the packet generator
  output logic                     noc_valid_o,
  output ravenoc_pkg::s_flit_req_t noc_flit_o,
  input  logic                     noc_ready_i,
  // Router port sending towards the packet generator
  input  logic                     rx_noc_valid_i,
  input  ravenoc_pkg::s_flit_req_t rx_noc_flit_i,
  output logic                     rx_noc_ready_o,
  // Packet generator receiving from the NoC
  output logic                     rx_axi_valid_o,
  output ravenoc_pkg::s_flit_req_t rx_axi_flit_o,
  input  logic                     rx_axi_ready_i
);
  import ravenoc_pkg::*;

  // AXI -> NoC FIFO hookup
  logic [FLIT_WIDTH-1:0] a2n_wr_data;
  logic [FLIT_WIDTH-1:0] a2n_rd_data;
  logic                  a2n_wr_en;
  logic                  a2n_rd_en;
  logic                  a2n_full;
  logic                  a2n_empty;

  // NoC -> AXI FIFO hookup
  logic [FLIT_WIDTH-1:0] n2a_wr_data;
  logic [FLIT_WIDTH-1:0] n2a_rd_data;
  logic                  n2a_wr_en;
  logic                  n2a_rd_en;
  logic                  n2a_full;
  logic                  n2a_empty;

  // Drop valid, only type and payload are stored
  function automatic logic [FLIT_WIDTH-1:0] strip_flit(input s_flit_req_t flit);
    return {flit.flit_type, flit.data};
  endfunction

  // Valid comes back from not-empty, all zeros while nothing is held
  function automatic s_flit_req_t rebuild_flit(input logic empty,
                                              input logic [FLIT_WIDTH-1:0] raw);
    return empty ? s_flit_req_t'('0) : s_flit_req_t'({1'b1, raw});
  endfunction

  //--------------------------------------------------------------------
  // AXI to NoC
  //--------------------------------------------------------------------
  always_comb begin : axi_to_noc_flow
    a2n_wr_data = strip_flit(axi_flit_i);
    if (bypass_cdc_i) begin
      // Same clock on both sides so wire straight across
      noc_valid_o = axi_valid_i;
      noc_flit_o  = axi_flit_i;
      axi_ready_o = noc_ready_i;
      a2n_wr_en   = 1'b0;
      a2n_rd_en   = 1'b0;
    end else begin
      axi_ready_o = ~a2n_full;
      noc_valid_o = ~a2n_empty;
      noc_flit_o  = rebuild_flit(a2n_empty, a2n_rd_data);
      // Push and pop only on a completed handshake
      a2n_wr_en   = axi_valid_i & axi_ready_o;
      a2n_rd_en   = noc_valid_o & noc_ready_i;
    end
  end

  async_gp_fifo #(
    .SLOTS (FIFO_SLOTS),
    .TAPS  (CDC_TAPS)
  ) u_afifo_axi_to_noc (
    .clk_wr     (clk_axi),
    .rst_n_i    (rst_n_i),
    .wr_en_i    (a2n_wr_en),
    .wr_data_i  (a2n_wr_data),
    .wr_full_o  (a2n_full),
    .clk_rd     (clk_noc),
    .rd_en_i    (a2n_rd_en),
    .rd_data_o  (a2n_rd_data),
    .rd_empty_o (a2n_empty)
  );

  //--------------------------------------------------------------------
  // NoC to AXI
  //--------------------------------------------------------------------
  always_comb begin : noc_to_axi_flow
    n2a_wr_data = strip_flit(rx_noc_flit_i);
    if (bypass_cdc_i) begin
      rx_axi_valid_o = rx_noc_valid_i;
      rx_axi_flit_o  = rx_noc_flit_i;
      rx_noc_ready_o = rx_axi_ready_i;
      n2a_wr_en      = 1'b0;
      n2a_rd_en      = 1'b0;
    end else begin
      rx_noc_ready_o = ~n2a_full;
      rx_axi_valid_o = ~n2a_empty;
      rx_axi_flit_o  = rebuild_flit(n2a_empty, n2a_rd_data);
      n2a_wr_en      = rx_noc_valid_i & rx_noc_ready_o;
      n2a_rd_en      = rx_axi_valid_o & rx_axi_ready_i;
    end
  end

  // Router side writes, packet generator side reads
  async_gp_fifo #(
    .SLOTS (FIFO_SLOTS),
    .TAPS  (CDC_TAPS)
  ) u_afifo_noc_to_axi (
    .clk_wr     (clk_noc),
    .rst_n_i    (rst_n_i),
    .wr_en_i    (n2a_wr_en),
    .wr_data_i  (n2a_wr_data),
    .wr_full_o  (n2a_full),
    .clk_rd     (clk_axi),
    .rd_en_i    (n2a_rd_en),
    .rd_data_o  (n2a_rd_data),
    .rd_empty_o (n2a_empty)
  );

endmodule

`default_nettype wire

// ==== src/async_gp_fifo.sv ====
`default_nettype none

module async_gp_fifo #(
  parameter int SLOTS = ravenoc_pkg::FIFO_SLOTS,
  parameter int TAPS  = ravenoc_pkg::CDC_TAPS
) (
  // Write domain
  input  logic                               clk_wr,
  input  logic                               rst_n_i,
  input  logic                               wr_en_i,
  input  logic [ravenoc_pkg::FLIT_WIDTH-1:0] wr_data_i,
  output logic                               wr_full_o,
  // Read domain
  input  logic                               clk_rd,
  input  logic                               rd_en_i,
  output logic [ravenoc_pkg::FLIT_WIDTH-1:0] rd_data_o,
  output logic                               rd_empty_o
);
  import ravenoc_pkg::*;

  // Slot index width, pointers carry one extra wrap bit
  localparam int IDX_WIDTH = PTR_WIDTH - 1;

  // Storage, written on clk_wr and read on clk_rd
  logic [FLIT_WIDTH-1:0] mem_q [SLOTS];

  // Write side pointers
  logic [PTR_WIDTH-1:0] wr_bin_q;
  logic [PTR_WIDTH-1:0] wr_gray_q;
  logic [PTR_WIDTH-1:0] wr_bin_next;
  logic                 wr_push;

  // Read side pointers
  logic [PTR_WIDTH-1:0] rd_bin_q;
  logic [PTR_WIDTH-1:0] rd_gray_q;
  logic [PTR_WIDTH-1:0] rd_bin_next;
  logic                 rd_pop;

  // Pointers after crossing
  logic [PTR_WIDTH-1:0] rd_gray_in_wr;
  logic [PTR_WIDTH-1:0] wr_gray_in_rd;

  // Pointer width only works for a power of two matching the package
  if (SLOTS != (1 << IDX_WIDTH)) begin : g_slots_check
    $error("async_gp_fifo SLOTS must equal 2**(PTR_WIDTH-1)");
  end

  // Binary to reflected Gray
  function automatic logic [PTR_WIDTH-1:0] bin2gray(input logic [PTR_WIDTH-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  //--------------------------------------------------------------------
  // Write domain
  //--------------------------------------------------------------------

  // Never push into a full FIFO even if the caller asks
  assign wr_push     = wr_en_i & ~wr_full_o;
  assign wr_bin_next = wr_bin_q + PTR_WIDTH'(1);

  always_ff @(posedge clk_wr) begin
    if (!rst_n_i) begin
      wr_bin_q  <= '0;
      wr_gray_q <= '0;
    end else if (wr_push) begin
      wr_bin_q  <= wr_bin_next;
      wr_gray_q <= bin2gray(wr_bin_next);
    end
  end

  // Payload array
  always_ff @(posedge clk_wr) begin
    if (wr_push) begin
      mem_q[wr_bin_q[IDX_WIDTH-1:0]] <= wr_data_i;
    end
  end

  // Full when one lap ahead of the read pointer
  // In Gray that means the top two bits flipped, the rest equal
  assign wr_full_o = (wr_gray_q == {~rd_gray_in_wr[PTR_WIDTH-1 -: 2],
                                     rd_gray_in_wr[PTR_WIDTH-3:0]});

  // Read pointer into the write domain
  ptr_sync #(
    .TAPS (TAPS)
  ) u_sync_rd_to_wr (
    .clk_i   (clk_wr),
    .rst_n_i (rst_n_i),
    .ptr_i   (rd_gray_q),
    .ptr_o   (rd_gray_in_wr)
  );

  //--------------------------------------------------------------------
  // Read domain
  //--------------------------------------------------------------------

  assign rd_pop      = rd_en_i & ~rd_empty_o;
  assign rd_bin_next = rd_bin_q + PTR_WIDTH'(1);

  always_ff @(posedge clk_rd) begin
    if (!rst_n_i) begin
      rd_bin_q  <= '0;
      rd_gray_q <= '0;
    end else if (rd_pop) begin
      rd_bin_q  <= rd_bin_next;
      rd_gray_q <= bin2gray(rd_bin_next);
    end
  end

  // Empty when both pointers sit on the same slot and lap
  assign rd_empty_o = (rd_gray_q == wr_gray_in_rd);

  // First word fall through, head slot always on the output
  assign rd_data_o = mem_q[rd_bin_q[IDX_WIDTH-1:0]];

  // Write pointer into the read domain
  ptr_sync #(
    .TAPS (TAPS)
  ) u_sync_wr_to_rd (
    .clk_i   (clk_rd),
    .rst_n_i (rst_n_i),
    .ptr_i   (wr_gray_q),
    .ptr_o   (wr_gray_in_rd)
  );

endmodule

`default_nettype wire

// ==== src/ptr_sync.sv ====
`default_nettype none

module ptr_sync #(
  parameter int TAPS = ravenoc_pkg::CDC_TAPS
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [ravenoc_pkg::PTR_WIDTH-1:0] ptr_i,
  output logic [ravenoc_pkg::PTR_WIDTH-1:0] ptr_o
);
  import ravenoc_pkg::*;

  // Crossing flops, stage 0 is the one that may go metastable
  // Input is Gray coded so only one bit moves per update
  logic [PTR_WIDTH-1:0] sync_q [TAPS];

  // A chain with no stage would be a plain wire
  if (TAPS < 1) begin : g_taps_check
    $error("ptr_sync needs at least one synchronizer stage");
  end

  //--------------------------------------------------------------------
  // Synchronizer chain on the destination clock
  //--------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < TAPS; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      // First capture of the foreign pointer
      sync_q[0] <= ptr_i;
      // Remaining stages let the first one settle
      for (int i = 1; i < TAPS; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Last stage is safe to use in this domain
  assign ptr_o = sync_q[TAPS-1];

endmodule

`default_nettype wire

// ==== src/ravenoc_pkg.sv ====
`default_nettype none

package ravenoc_pkg;

  //--------------------------------------------------------------------
  // Flit geometry
  //--------------------------------------------------------------------

  // Payload bits carried by every flit
  localparam int FLIT_DATA_WIDTH = 32;

  // Width of the flit kind field
  localparam int FLIT_TYPE_WIDTH = 2;

  // What the FIFO actually stores, valid is not kept
  localparam int FLIT_WIDTH = FLIT_TYPE_WIDTH + FLIT_DATA_WIDTH;

  //--------------------------------------------------------------------
  // CDC FIFO sizing
  //--------------------------------------------------------------------

  // Slots per direction, power of two only
  localparam int FIFO_SLOTS = 4;

  // Flops in each pointer synchronizer
  localparam int CDC_TAPS = 2;

  // Slot index plus one wrap bit
  localparam int PTR_WIDTH = $clog2(FIFO_SLOTS) + 1;

  //--------------------------------------------------------------------
  // Flit types
  //--------------------------------------------------------------------

  // Position of a flit inside its packet
  typedef enum logic [FLIT_TYPE_WIDTH-1:0] {
    HEAD_FLIT      = 2'b00,
    BODY_FLIT      = 2'b01,
    TAIL_FLIT      = 2'b10,
    HEAD_TAIL_FLIT = 2'b11
  } flit_type_t;

  // Flit as seen on the router and packet generator ports
  // Valid sits on top so the lower bits match the stored format
  typedef struct packed {
    logic                       valid;
    flit_type_t                 flit_type;
    logic [FLIT_DATA_WIDTH-1:0] data;
  } s_flit_req_t;

endpackage

`default_nettype wire
